/* Bender.yml */
package:
  name: nbody_top

sources:
  # Packages
  - src/nbody_bus_pkg.sv
  - src/nbody_sim_pkg.sv
  # RTL
  - src/nbody_regs.sv
  - src/nbody_state_ram.sv
  - src/nbody_drift_engine.sv
  - src/nbody_top.sv
  # Testbench
  - target: test
    files:
      - dv/nbody_tb.sv

/* dv/nbody_tb.sv */
// Testbench for the N-body drift accelerator with APB stimulus and a drift reference model
`timescale 1ns/10ps

module nbody_tb
    import nbody_bus_pkg::*;
    import nbody_sim_pkg::*;
();

    localparam int N_MAX         = 512;
    localparam int READY_TIMEOUT = 8;
    localparam int DONE_POLLS    = 1000;
    localparam int DRAIN_CYCLES  = 10;

    logic                  clk;
    logic                  rst;
    logic [BUS_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [BUS_DATA_W-1:0] pwdata;
    logic [BUS_DATA_W-1:0] prdata;
    logic                  pready;

    // Model of the body memories
    logic [COORD_W-1:0] mx [N_MAX];
    logic [COORD_W-1:0] my [N_MAX];
    logic [COORD_W-1:0] mvx [N_MAX];
    logic [COORD_W-1:0] mvy [N_MAX];

    // Pending checks for the compare process
    string              name_q [$];
    logic [COORD_W-1:0] exp_q [$];
    logic [COORD_W-1:0] act_q [$];

    nbody_top #(.N_BODIES_MAX(N_MAX)) DUT (
        .clk(clk), .rst(rst),
        .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Position after a number of drift steps with modulo 2^64 wrap
    function automatic logic [COORD_W-1:0] drift_ref(input logic [COORD_W-1:0] pos,
                                                     input logic [COORD_W-1:0] vel,
                                                     input logic [31:0] steps);
        logic [COORD_W-1:0] n;
        n = (steps == 0) ? 64'd1 : 64'(steps);
        return pos + vel * n;
    endfunction

    function automatic logic [BUS_ADDR_W-1:0] make_addr(input logic [FIELD_W-1:0] field,
                                                        input int idx);
        return {field, body_idx_t'(idx)};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic queue_check(input string name, input logic [COORD_W-1:0] exp_val,
                               input logic [COORD_W-1:0] act_val);
        name_q.push_back(name);
        exp_q.push_back(exp_val);
        act_q.push_back(act_val);
    endtask

    // Sample pready at the falling edge of each access cycle
    task automatic wait_ready(output logic [BUS_DATA_W-1:0] data);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!pready) begin
            assert (cycles < READY_TIMEOUT) else stop_on_error("Timeout waiting for pready_o");
            cycles++;
            @(negedge clk);
        end
        data = prdata;
    endtask

    task automatic transfer(input logic write, input logic [BUS_ADDR_W-1:0] addr,
                            input logic [BUS_DATA_W-1:0] wdata,
                            output logic [BUS_DATA_W-1:0] rdata);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        wait_ready(rdata);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_word(input logic [BUS_ADDR_W-1:0] addr,
                              input logic [BUS_DATA_W-1:0] data);
        logic [BUS_DATA_W-1:0] unused;
        transfer(1'b1, addr, data, unused);
    endtask

    task automatic fetch_word(input logic [BUS_ADDR_W-1:0] addr,
                              output logic [BUS_DATA_W-1:0] data);
        transfer(1'b0, addr, '0, data);
    endtask

    // Upper half write commits the staged lower half
    task automatic write_body(input int idx);
        write_word(make_addr(X_LO, idx), mx[idx][31:0]);
        write_word(make_addr(X_HI, idx), mx[idx][63:32]);
        write_word(make_addr(Y_LO, idx), my[idx][31:0]);
        write_word(make_addr(Y_HI, idx), my[idx][63:32]);
        write_word(make_addr(VX_LO, idx), mvx[idx][31:0]);
        write_word(make_addr(VX_HI, idx), mvx[idx][63:32]);
        write_word(make_addr(VY_LO, idx), mvy[idx][31:0]);
        write_word(make_addr(VY_HI, idx), mvy[idx][63:32]);
    endtask

    task automatic check_bodies(input int total);
        logic [BUS_DATA_W-1:0] lo;
        logic [BUS_DATA_W-1:0] hi;
        for (int i = 0; i < total; i++) begin
            fetch_word(make_addr(X_LO, i), lo);
            fetch_word(make_addr(X_HI, i), hi);
            queue_check($sformatf("x[%0d]", i), mx[i], {hi, lo});
            fetch_word(make_addr(Y_LO, i), lo);
            fetch_word(make_addr(Y_HI, i), hi);
            queue_check($sformatf("y[%0d]", i), my[i], {hi, lo});
        end
    endtask

    task automatic start_run(input int n, input int gap);
        write_word(make_addr(NBODIES, 0), n);
        write_word(make_addr(GAP, 0), gap);
        write_word(make_addr(CTRL, 0), 32'h1);
    endtask

    task automatic wait_done();
        logic [BUS_DATA_W-1:0] status;
        int polls;
        polls = 0;
        fetch_word(make_addr(STATUS, 0), status);
        while (!status[0]) begin
            assert (polls < DONE_POLLS) else stop_on_error("Timeout waiting for DONE in STATUS");
            polls++;
            fetch_word(make_addr(STATUS, 0), status);
        end
    endtask

    task automatic advance_model(input int n, input int gap);
        for (int i = 0; i < n; i++) begin
            mx[i] = drift_ref(mx[i], mvx[i], gap);
            my[i] = drift_ref(my[i], mvy[i], gap);
        end
    endtask

    task automatic expect_reg(input string name, input logic [FIELD_W-1:0] field,
                              input logic [BUS_DATA_W-1:0] value);
        logic [BUS_DATA_W-1:0] data;
        fetch_word(make_addr(field, 0), data);
        queue_check(name, value, data);
    endtask

    task automatic expect_ones(input logic [FIELD_W-1:0] field, input int idx);
        logic [BUS_DATA_W-1:0] data;
        fetch_word(make_addr(field, idx), data);
        queue_check($sformatf("field 0x%02h", field), 64'hffff_ffff, data);
    endtask

    task automatic fill_random(input int idx);
        mx[idx]  = {$urandom, $urandom};
        my[idx]  = {$urandom, $urandom};
        mvx[idx] = {$urandom, $urandom};
        mvy[idx] = {$urandom, $urandom};
    endtask

    // Compare process
    initial begin
        string              name;
        logic [COORD_W-1:0] exp_val;
        logic [COORD_W-1:0] act_val;
        forever begin
            @(negedge clk);
            while (act_q.size() > 0) begin
                name    = name_q.pop_front();
                exp_val = exp_q.pop_front();
                act_val = act_q.pop_front();
                assert (act_val === exp_val) else stop_on_error(
                    $sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, exp_val, act_val));
            end
        end
    end

    initial begin
        int unsigned           seed;
        logic [BUS_DATA_W-1:0] word;
        int                    drain;
        seed    = 32'hb998e751;
        void'($urandom(seed));
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Idle readback and half staging
        expect_reg("STATUS", STATUS, 32'h0);
        expect_reg("CTRL", CTRL, 32'h0);
        expect_reg("NBODIES", NBODIES, 32'h0);
        expect_reg("GAP", GAP, 32'h0);
        mx[0]  = '0;
        my[0]  = '0;
        mvx[0] = '0;
        mvy[0] = '0;
        write_body(0);
        for (int i = 1; i < 4; i++) begin
            fill_random(i);
            write_body(i);
        end
        check_bodies(4);

        // Single step with positions near the sign and wrap points
        for (int i = 0; i < 8; i++) begin
            fill_random(i);
            mx[i]  = (i % 2 == 0) ? {32'h7fff_ffff, $urandom} : {32'hffff_ffff, $urandom};
            mvx[i] = {32'h0000_0001, $urandom};
            write_body(i);
        end
        start_run(8, 1);
        wait_done();
        advance_model(8, 1);
        check_bodies(8);

        // Five steps over 37 of 40 bodies
        for (int i = 0; i < 40; i++) begin
            fill_random(i);
            write_body(i);
        end
        start_run(37, 5);
        wait_done();
        advance_model(37, 5);
        check_bodies(40);

        // DONE stays set until the next GO
        expect_reg("STATUS", STATUS, 32'h1);
        expect_reg("STATUS", STATUS, 32'h1);
        expect_reg("CTRL", CTRL, 32'h1);
        expect_reg("NBODIES", NBODIES, 32'd37);
        expect_reg("GAP", GAP, 32'd5);
        start_run(37, 5);
        expect_reg("STATUS", STATUS, 32'h2);
        wait_done();
        advance_model(37, 5);
        check_bodies(40);

        // GAP of zero runs one step
        start_run(4, 0);
        wait_done();
        advance_model(4, 0);
        check_bodies(8);

        // Write-only and unmapped fields
        expect_ones(VX_LO, 3);
        expect_ones(VX_HI, 3);
        expect_ones(VY_LO, 3);
        expect_ones(VY_HI, 3);
        expect_ones(7'h0c, 0);
        expect_ones(7'h7f, 5);

        drain = 0;
        while (act_q.size() > 0 && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        if (act_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_on_error("Compare queue did not drain");
        end
    end

endmodule

/* nbody_top.f */
src/nbody_bus_pkg.sv
src/nbody_sim_pkg.sv
src/nbody_regs.sv
src/nbody_state_ram.sv
src/nbody_drift_engine.sv
src/nbody_top.sv
dv/nbody_tb.sv

/* src/nbody_bus_pkg.sv */
// N-body bus map: APB widths and the field codes in the upper address bits
package nbody_bus_pkg;

    // APB data and address widths
    localparam int BUS_DATA_W = 32;
    localparam int BUS_ADDR_W = 16;

    // Upper address bits select the field, the rest carry the body index
    localparam int FIELD_W = 7;

    typedef enum logic [FIELD_W-1:0] {
        // Control registers
        CTRL    = 7'h00,
        STATUS  = 7'h01,
        NBODIES = 7'h02,
        GAP     = 7'h03,
        // Position halves, lower half is staged until the upper one arrives
        X_LO    = 7'h04,
        X_HI    = 7'h05,
        Y_LO    = 7'h06,
        Y_HI    = 7'h07,
        // Velocity halves, write only
        VX_LO   = 7'h08,
        VX_HI   = 7'h09,
        VY_LO   = 7'h0a,
        VY_HI   = 7'h0b
    } bus_field_e;

endpackage

/* src/nbody_drift_engine.sv */
// N-body drift engine: step sequencer, x += vx / y += vy pipeline, memory port steering
`timescale 1ns/10ps

module nbody_drift_engine
    import nbody_bus_pkg::*;
    import nbody_sim_pkg::*;
#(
    parameter int N_BODIES_MAX = MAX_BODIES,
    parameter int SUM_STAGES   = 1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start_i,
    input  logic [$clog2(N_BODIES_MAX+1)-1:0] n_bodies_i,
    input  logic [BUS_DATA_W-1:0]             gap_i,
    input  logic [$clog2(N_BODIES_MAX)-1:0]   bus_addr_i,
    input  logic [COORD_W-1:0]                bus_wdata_i,
    input  logic                              bus_pos_we_x_i,
    input  logic                              bus_pos_we_y_i,
    input  logic                              bus_vel_we_x_i,
    input  logic                              bus_vel_we_y_i,
    input  logic                              bus_rd_i,
    input  logic [COORD_W-1:0]                pos_rx_i,
    input  logic [COORD_W-1:0]                pos_ry_i,
    input  logic [COORD_W-1:0]                vel_rx_i,
    input  logic [COORD_W-1:0]                vel_ry_i,
    output logic                              busy_o,
    output logic                              finish_o,
    output logic [COORD_W-1:0]                rd_x_o,
    output logic [COORD_W-1:0]                rd_y_o,
    output logic                              pos_we_x_o,
    output logic                              pos_we_y_o,
    output logic [$clog2(N_BODIES_MAX)-1:0]   pos_waddr_o,
    output logic [COORD_W-1:0]                pos_wx_o,
    output logic [COORD_W-1:0]                pos_wy_o,
    output logic [$clog2(N_BODIES_MAX)-1:0]   pos_raddr_o,
    output logic                              vel_we_x_o,
    output logic                              vel_we_y_o,
    output logic [$clog2(N_BODIES_MAX)-1:0]   vel_waddr_o,
    output logic [COORD_W-1:0]                vel_wx_o,
    output logic [COORD_W-1:0]                vel_wy_o,
    output logic [$clog2(N_BODIES_MAX)-1:0]   vel_raddr_o
);

    localparam int IDX_W = $clog2(N_BODIES_MAX);
    // Step cycle counter spans n reads plus the pipeline drain
    localparam int CYC_W = $clog2(N_BODIES_MAX + SUM_STAGES + 1);

    run_state_e            state_q;
    logic [CYC_W-1:0]      cyc_q;
    logic [BUS_DATA_W-1:0] step_q;
    logic                  finish_q;
    logic [SUM_STAGES:0]   vld_q;
    logic [IDX_W-1:0]      idx_q [SUM_STAGES+1];
    logic [COORD_W-1:0]    sum_x_q [1:SUM_STAGES];
    logic [COORD_W-1:0]    sum_y_q [1:SUM_STAGES];
    logic                  rd_pend_q;
    logic [COORD_W-1:0]    rd_x_q;
    logic [COORD_W-1:0]    rd_y_q;
    logic                  busy;
    logic                  issue;
    logic                  step_end;
    logic                  last_step;

    assign busy     = (state_q == DRIFT);
    assign issue    = busy && (cyc_q < CYC_W'(n_bodies_i));
    assign step_end = busy && (cyc_q == CYC_W'(n_bodies_i) + CYC_W'(SUM_STAGES));
    // GAP of zero runs a single step
    assign last_step = (gap_i == '0) || (step_q == gap_i - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= IDLE;
            cyc_q    <= '0;
            step_q   <= '0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= DRIFT;
                        cyc_q   <= '0;
                        step_q  <= '0;
                    end
                end
                DRIFT: begin
                    if (step_end) begin
                        cyc_q <= '0;
                        if (last_step) begin
                            state_q  <= IDLE;
                            finish_q <= 1'b1;
                        end else begin
                            step_q <= step_q + 1'b1;
                        end
                    end else begin
                        cyc_q <= cyc_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Valid bits follow each body from read to write back
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q     <= '0;
            rd_pend_q <= 1'b0;
        end else begin
            vld_q     <= {vld_q[SUM_STAGES-1:0], issue};
            rd_pend_q <= bus_rd_i;
        end
    end

    always_ff @(posedge clk) begin
        idx_q[0]   <= cyc_q[IDX_W-1:0];
        sum_x_q[1] <= pos_rx_i + vel_rx_i;
        sum_y_q[1] <= pos_ry_i + vel_ry_i;
        for (int j = 1; j <= SUM_STAGES; j++) begin
            idx_q[j] <= idx_q[j-1];
        end
        for (int j = 2; j <= SUM_STAGES; j++) begin
            sum_x_q[j] <= sum_x_q[j-1];
            sum_y_q[j] <= sum_y_q[j-1];
        end
        // Hold bus read data once the memory has answered
        if (rd_pend_q) begin
            rd_x_q <= pos_rx_i;
            rd_y_q <= pos_ry_i;
        end
    end

    // Bus owns the memories when idle; pipeline owns them during a run
    always_comb begin
        pos_raddr_o = bus_addr_i;
        vel_raddr_o = bus_addr_i;
        pos_waddr_o = bus_addr_i;
        pos_wx_o    = bus_wdata_i;
        pos_wy_o    = bus_wdata_i;
        pos_we_x_o  = bus_pos_we_x_i;
        pos_we_y_o  = bus_pos_we_y_i;
        vel_waddr_o = bus_addr_i;
        vel_wx_o    = bus_wdata_i;
        vel_wy_o    = bus_wdata_i;
        vel_we_x_o  = bus_vel_we_x_i;
        vel_we_y_o  = bus_vel_we_y_i;
        if (busy) begin
            pos_raddr_o = cyc_q[IDX_W-1:0];
            vel_raddr_o = cyc_q[IDX_W-1:0];
            pos_waddr_o = idx_q[SUM_STAGES];
            pos_wx_o    = sum_x_q[SUM_STAGES];
            pos_wy_o    = sum_y_q[SUM_STAGES];
            pos_we_x_o  = vld_q[SUM_STAGES];
            pos_we_y_o  = vld_q[SUM_STAGES];
            vel_we_x_o  = 1'b0;
            vel_we_y_o  = 1'b0;
        end
    end

    assign busy_o   = busy;
    assign finish_o = finish_q;
    assign rd_x_o   = rd_x_q;
    assign rd_y_o   = rd_y_q;

endmodule

/* src/nbody_regs.sv */
// N-body register block: APB slave, control registers, half-word staging and readback
`timescale 1ns/10ps

module nbody_regs
    import nbody_bus_pkg::*;
    import nbody_sim_pkg::*;
#(
    parameter int N_BODIES_MAX = MAX_BODIES
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [BUS_ADDR_W-1:0]             paddr_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [BUS_DATA_W-1:0]             pwdata_i,
    output logic [BUS_DATA_W-1:0]             prdata_o,
    output logic                              pready_o,
    input  logic                              finish_i,
    input  logic                              busy_i,
    input  logic [COORD_W-1:0]                rd_x_i,
    input  logic [COORD_W-1:0]                rd_y_i,
    output logic                              start_o,
    output logic [$clog2(N_BODIES_MAX+1)-1:0] n_bodies_o,
    output logic [BUS_DATA_W-1:0]             gap_o,
    output logic [$clog2(N_BODIES_MAX)-1:0]   bus_addr_o,
    output logic [COORD_W-1:0]                bus_wdata_o,
    output logic                              bus_pos_we_x_o,
    output logic                              bus_pos_we_y_o,
    output logic                              bus_vel_we_x_o,
    output logic                              bus_vel_we_y_o,
    output logic                              bus_rd_o
);

    localparam int IDX_W = $clog2(N_BODIES_MAX);
    localparam int CNT_W = $clog2(N_BODIES_MAX + 1);

    bus_field_e            field;
    body_idx_t             body_idx;
    logic                  wr_en;
    logic                  pos_rd;
    logic                  wait_q;
    logic                  go_q;
    logic                  start_q;
    logic                  done_q;
    logic [CNT_W-1:0]      n_bodies_q;
    logic [BUS_DATA_W-1:0] gap_q;
    logic [BUS_DATA_W-1:0] lo_q;
    coord_u                wdata_u;
    coord_u                rx_u;
    coord_u                ry_u;

    // Field in the top bits, body number below
    assign field    = bus_field_e'(paddr_i[BUS_ADDR_W-1 -: FIELD_W]);
    assign body_idx = paddr_i[$bits(body_idx_t)-1:0];

    assign wr_en  = psel_i & penable_i & pwrite_i;
    assign pos_rd = ~pwrite_i & (field inside {X_LO, X_HI, Y_LO, Y_HI});

    // Position reads take one extra cycle for the memory hop
    assign pready_o = psel_i & penable_i & (~pos_rd | wait_q);
    assign bus_rd_o = psel_i & ~penable_i & pos_rd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_q     <= 1'b0;
            go_q       <= 1'b0;
            start_q    <= 1'b0;
            done_q     <= 1'b0;
            n_bodies_q <= '0;
            gap_q      <= '0;
            lo_q       <= '0;
        end else begin
            start_q <= 1'b0;
            wait_q  <= psel_i & penable_i & ~pready_o;
            if (finish_i) begin
                done_q <= 1'b1;
            end
            if (wr_en) begin
                case (field)
                    CTRL: begin
                        go_q    <= pwdata_i[0];
                        start_q <= pwdata_i[0];
                        done_q  <= 1'b0;
                    end
                    NBODIES: n_bodies_q <= pwdata_i[CNT_W-1:0];
                    GAP:     gap_q <= pwdata_i;
                    X_LO, Y_LO, VX_LO, VY_LO: lo_q <= pwdata_i;
                    default: ;
                endcase
            end
        end
    end

    // Upper half comes straight off the bus with the staged lower half
    always_comb begin
        wdata_u.half.hi = pwdata_i;
        wdata_u.half.lo = lo_q;
        rx_u            = rd_x_i;
        ry_u            = rd_y_i;
        case (field)
            CTRL:    prdata_o = {{(BUS_DATA_W-1){1'b0}}, go_q};
            STATUS:  prdata_o = {{(BUS_DATA_W-2){1'b0}}, busy_i, done_q};
            NBODIES: prdata_o = {{(BUS_DATA_W-CNT_W){1'b0}}, n_bodies_q};
            GAP:     prdata_o = gap_q;
            X_LO:    prdata_o = rx_u.half.lo;
            X_HI:    prdata_o = rx_u.half.hi;
            Y_LO:    prdata_o = ry_u.half.lo;
            Y_HI:    prdata_o = ry_u.half.hi;
            default: prdata_o = '1;
        endcase
    end

    assign bus_wdata_o    = wdata_u.word;
    assign bus_addr_o     = body_idx[IDX_W-1:0];
    assign bus_pos_we_x_o = wr_en & (field == X_HI);
    assign bus_pos_we_y_o = wr_en & (field == Y_HI);
    assign bus_vel_we_x_o = wr_en & (field == VX_HI);
    assign bus_vel_we_y_o = wr_en & (field == VY_HI);

    assign start_o    = start_q;
    assign n_bodies_o = n_bodies_q;
    assign gap_o      = gap_q;

endmodule

/* src/nbody_sim_pkg.sv */
// N-body simulation data: body capacity, fixed point coordinates, run state
package nbody_sim_pkg;

    // Default capacity of the body memories
    localparam int MAX_BODIES = 512;

    // Signed fixed point coordinate, wraps modulo 2^64
    localparam int COORD_W = 64;

    // Index carried in the low address bits
    typedef logic [8:0] body_idx_t;

    typedef struct packed {
        logic [COORD_W/2-1:0] hi;
        logic [COORD_W/2-1:0] lo;
    } coord_halves_t;

    // Same coordinate seen as one word or as two bus halves
    typedef union packed {
        logic [COORD_W-1:0] word;
        coord_halves_t      half;
    } coord_u;

    // Engine states
    typedef enum logic {
        IDLE  = 1'b0,
        DRIFT = 1'b1
    } run_state_e;

endpackage

/* src/nbody_state_ram.sv */
// N-body state memory: one x/y coordinate pair per body, per-lane write, registered read
`timescale 1ns/10ps

module nbody_state_ram
    import nbody_sim_pkg::*;
#(
    parameter int N_BODIES_MAX = MAX_BODIES
) (
    input  logic                            clk,
    input  logic                            we_x_i,
    input  logic                            we_y_i,
    input  logic [$clog2(N_BODIES_MAX)-1:0] waddr_i,
    input  logic [COORD_W-1:0]              wdata_x_i,
    input  logic [COORD_W-1:0]              wdata_y_i,
    input  logic [$clog2(N_BODIES_MAX)-1:0] raddr_i,
    output logic [COORD_W-1:0]              rdata_x_o,
    output logic [COORD_W-1:0]              rdata_y_o
);

    logic [COORD_W-1:0] mem_x [N_BODIES_MAX];
    logic [COORD_W-1:0] mem_y [N_BODIES_MAX];

    // Lanes written independently
    always_ff @(posedge clk) begin
        if (we_x_i) begin
            mem_x[waddr_i] <= wdata_x_i;
        end
        if (we_y_i) begin
            mem_y[waddr_i] <= wdata_y_i;
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge clk) begin
        rdata_x_o <= mem_x[raddr_i];
        rdata_y_o <= mem_y[raddr_i];
    end

endmodule

/* src/nbody_top.sv */
// N-body drift accelerator top: APB register block, drift engine, position and velocity memories
`timescale 1ns/10ps

module nbody_top
    import nbody_bus_pkg::*;
    import nbody_sim_pkg::*;
#(
    parameter int N_BODIES_MAX = MAX_BODIES
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [BUS_ADDR_W-1:0] paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [BUS_DATA_W-1:0] pwdata_i,
    output logic [BUS_DATA_W-1:0] prdata_o,
    output logic                  pready_o
);

    localparam int IDX_W = $clog2(N_BODIES_MAX);
    localparam int CNT_W = $clog2(N_BODIES_MAX + 1);

    logic                  start, busy, finish, bus_rd;
    logic [CNT_W-1:0]      n_bodies;
    logic [BUS_DATA_W-1:0] gap;
    logic [IDX_W-1:0]      bus_addr;
    logic [COORD_W-1:0]    bus_wdata, rd_x, rd_y;
    logic                  bus_pos_we_x, bus_pos_we_y, bus_vel_we_x, bus_vel_we_y;
    // Memory ports
    logic                  pos_we_x, pos_we_y, vel_we_x, vel_we_y;
    logic [IDX_W-1:0]      pos_waddr, pos_raddr, vel_waddr, vel_raddr;
    logic [COORD_W-1:0]    pos_wx, pos_wy, vel_wx, vel_wy;
    logic [COORD_W-1:0]    pos_rx, pos_ry, vel_rx, vel_ry;

    nbody_regs #(.N_BODIES_MAX(N_BODIES_MAX)) u_regs (
        .clk(clk), .rst(rst),
        .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
        .pwrite_i(pwrite_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o),
        .finish_i(finish), .busy_i(busy), .rd_x_i(rd_x), .rd_y_i(rd_y),
        .start_o(start), .n_bodies_o(n_bodies), .gap_o(gap),
        .bus_addr_o(bus_addr), .bus_wdata_o(bus_wdata),
        .bus_pos_we_x_o(bus_pos_we_x), .bus_pos_we_y_o(bus_pos_we_y),
        .bus_vel_we_x_o(bus_vel_we_x), .bus_vel_we_y_o(bus_vel_we_y),
        .bus_rd_o(bus_rd)
    );

    nbody_drift_engine #(.N_BODIES_MAX(N_BODIES_MAX)) u_engine (
        .clk(clk), .rst(rst),
        .start_i(start), .n_bodies_i(n_bodies), .gap_i(gap),
        .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata),
        .bus_pos_we_x_i(bus_pos_we_x), .bus_pos_we_y_i(bus_pos_we_y),
        .bus_vel_we_x_i(bus_vel_we_x), .bus_vel_we_y_i(bus_vel_we_y),
        .bus_rd_i(bus_rd),
        .pos_rx_i(pos_rx), .pos_ry_i(pos_ry), .vel_rx_i(vel_rx), .vel_ry_i(vel_ry),
        .busy_o(busy), .finish_o(finish), .rd_x_o(rd_x), .rd_y_o(rd_y),
        .pos_we_x_o(pos_we_x), .pos_we_y_o(pos_we_y), .pos_waddr_o(pos_waddr),
        .pos_wx_o(pos_wx), .pos_wy_o(pos_wy), .pos_raddr_o(pos_raddr),
        .vel_we_x_o(vel_we_x), .vel_we_y_o(vel_we_y), .vel_waddr_o(vel_waddr),
        .vel_wx_o(vel_wx), .vel_wy_o(vel_wy), .vel_raddr_o(vel_raddr)
    );

    nbody_state_ram #(.N_BODIES_MAX(N_BODIES_MAX)) u_pos_ram (
        .clk(clk), .we_x_i(pos_we_x), .we_y_i(pos_we_y), .waddr_i(pos_waddr),
        .wdata_x_i(pos_wx), .wdata_y_i(pos_wy), .raddr_i(pos_raddr),
        .rdata_x_o(pos_rx), .rdata_y_o(pos_ry)
    );

    nbody_state_ram #(.N_BODIES_MAX(N_BODIES_MAX)) u_vel_ram (
        .clk(clk), .we_x_i(vel_we_x), .we_y_i(vel_we_y), .waddr_i(vel_waddr),
        .wdata_x_i(vel_wx), .wdata_y_i(vel_wy), .raddr_i(vel_raddr),
        .rdata_x_o(vel_rx), .rdata_y_o(vel_ry)
    );

endmodule
